//--- hw/dircc_types_pkg.sv
package dircc_types_pkg;

  localparam int beat_width     = 32;
  localparam int frame_beats    = 8;
  localparam int rx_fifo_depth  = 8;
  localparam int tx_queue_depth = 2;

  // node address as carried in two beats
  typedef struct packed {
    logic [31:0] hw_addr;
    logic [15:0] sw_addr;
    logic [6:0]  port;
    logic        flag;
  } addr_t;

  typedef struct packed {
    addr_t       dest_addr;
    addr_t       src_addr;
    logic [31:0] lamport;
    logic [95:0] data;
  } packet_t;

  // one stream word with its framing marks
  typedef struct packed {
    logic [beat_width-1:0] data;
    logic                  startofpacket;
    logic                  endofpacket;
  } beat_t;

  typedef logic [$clog2(frame_beats)-1:0] beat_idx_t;

  localparam beat_idx_t last_beat = beat_idx_t'(frame_beats - 1);

endpackage

//--- hw/st_beat_if.sv
`timescale 1ns/1ps

interface st_beat_if;

  logic [dircc_types_pkg::beat_width-1:0] data;
  logic                                   startofpacket;
  logic                                   endofpacket;
  logic                                   valid;
  logic                                   ready;

  modport source (
    output data,
    output startofpacket,
    output endofpacket,
    output valid,
    input  ready
  );

  modport sink (
    input  data,
    input  startofpacket,
    input  endofpacket,
    input  valid,
    output ready
  );

endinterface

//--- hw/st_fifo.sv
`timescale 1ns/1ps

module st_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     reset_n,

  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,

  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic [cnt_w-1:0] count;
  logic             wr;
  logic             rd;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1; // wraps for any depth
  endfunction

  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];                      // first word fall-through
  assign in_ready  = (count != cnt_w'(depth)) || out_ready; // full but draining
  assign wr        = in_valid && in_ready;
  assign rd        = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({wr, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hw/dircc_avalon_st_packet_receiver.sv
`timescale 1ns/1ps

module dircc_avalon_st_packet_receiver (
  input  logic                                   clk,
  input  logic                                   reset_n,
  input  logic                                   booting,

  input  logic [dircc_types_pkg::beat_width-1:0] rx_data,
  input  logic                                   rx_startofpacket,
  input  logic                                   rx_endofpacket,
  input  logic                                   rx_valid,
  output logic                                   rx_ready,

  output logic                                   pkt_out_valid,
  output dircc_types_pkg::packet_t               pkt_out,

  output logic                                   receive_done,
  output logic                                   receive_nearly_done,
  output logic                                   framing_error
);

  typedef enum logic [2:0] {
    s_dest_hw, s_dest_sw, s_src_hw, s_src_sw, s_lamport, s_data0, s_data1, s_data2
  } state_t;

  dircc_types_pkg::beat_t   rx_beat;
  dircc_types_pkg::beat_t   head_beat;
  dircc_types_pkg::packet_t staging;
  state_t                   state;
  state_t                   state_next;
  logic                     hunt;       // skipping the rest of a broken frame
  logic                     hunt_next;
  logic                     rd_en;
  logic                     take;
  logic                     first_beat;
  logic                     advance;
  logic                     err;

  st_beat_if fifo_out ();

  assign rx_beat = '{data: rx_data, startofpacket: rx_startofpacket,
                     endofpacket: rx_endofpacket};

  st_fifo #(
    .payload_t (dircc_types_pkg::beat_t),
    .depth     (dircc_types_pkg::rx_fifo_depth)
  ) input_fifo (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_valid  (rx_valid),
    .in_data   (rx_beat),
    .in_ready  (rx_ready),
    .out_valid (fifo_out.valid),
    .out_data  (head_beat),
    .out_ready (fifo_out.ready)
  );

  assign fifo_out.data          = head_beat.data;
  assign fifo_out.startofpacket = head_beat.startofpacket;
  assign fifo_out.endofpacket   = head_beat.endofpacket;
  assign fifo_out.ready         = rd_en;
  assign take                   = fifo_out.valid && fifo_out.ready;

  always_comb begin
    state_next = state;
    hunt_next  = hunt;
    err        = 1'b0;
    advance    = 1'b0;
    first_beat = 1'b0;
    if (take) begin
      if (fifo_out.startofpacket && !fifo_out.endofpacket) begin
        first_beat = 1'b1;
        state_next = s_dest_sw;
        hunt_next  = 1'b0;
        err        = (state != s_dest_hw); // restart mid-frame
      end else if (fifo_out.startofpacket) begin
        err        = 1'b1;                  // one-beat frame
        state_next = s_dest_hw;
        hunt_next  = 1'b0;
      end else if (state == s_dest_hw) begin
        err       = !hunt;                  // missing sop, flag once
        hunt_next = 1'b1;
      end else if (fifo_out.endofpacket != (state == s_data2)) begin
        // eop too early, or missing on the last beat
        err        = 1'b1;
        state_next = s_dest_hw;
        hunt_next  = !fifo_out.endofpacket;
      end else begin
        advance    = 1'b1;
        state_next = (state == s_data2) ? s_dest_hw : state_t'(state + 3'd1);
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state               <= s_dest_hw;
      hunt                <= 1'b0;
      rd_en               <= 1'b0;
      framing_error       <= 1'b0;
      receive_nearly_done <= 1'b0;
      receive_done        <= 1'b0;
      pkt_out_valid       <= 1'b0;
    end else begin
      state               <= state_next;
      hunt                <= hunt_next;
      rd_en               <= !booting;
      framing_error       <= err;
      receive_nearly_done <= advance && (state == s_data1);
      receive_done        <= advance && (state == s_data2);
      pkt_out_valid       <= advance && (state == s_data2);
    end
  end

  always_ff @(posedge clk) begin
    if (first_beat) begin
      staging.dest_addr.hw_addr <= fifo_out.data;
    end
    if (advance) begin
      case (state)
        s_dest_sw: begin
          {staging.dest_addr.sw_addr, staging.dest_addr.port,
           staging.dest_addr.flag} <= fifo_out.data[31:8];
        end
        s_src_hw:  staging.src_addr.hw_addr <= fifo_out.data;
        s_src_sw: begin
          {staging.src_addr.sw_addr, staging.src_addr.port,
           staging.src_addr.flag} <= fifo_out.data[31:8];
        end
        s_lamport: staging.lamport <= fifo_out.data;
        s_data0:   staging.data[31:0] <= fifo_out.data;
        s_data1:   staging.data[63:32] <= fifo_out.data;
        s_data2: begin
          pkt_out              <= staging;
          pkt_out.data[95:64]  <= fifo_out.data; // last word straight from the beat
        end
        default: ;
      endcase
    end
  end

endmodule

//--- hw/dircc_avalon_st_packet_sender.sv
`timescale 1ns/1ps

module dircc_avalon_st_packet_sender (
  input  logic                                   clk,
  input  logic                                   reset_n,

  input  logic                                   pkt_in_valid,
  input  dircc_types_pkg::packet_t               pkt_in,
  output logic                                   pkt_in_ready,

  output logic [dircc_types_pkg::beat_width-1:0] tx_data,
  output logic                                   tx_startofpacket,
  output logic                                   tx_endofpacket,
  output logic                                   tx_valid,
  input  logic                                   tx_ready
);

  dircc_types_pkg::packet_t  head_pkt;
  dircc_types_pkg::beat_idx_t beat_idx;   // next beat to load
  logic                      head_valid;
  logic                      drained;     // head fully loaded, waiting for pop
  logic                      pop;
  logic                      load;

  st_beat_if tx_beat ();

  function automatic logic [dircc_types_pkg::beat_width-1:0] beat_word(
    input dircc_types_pkg::packet_t   p,
    input dircc_types_pkg::beat_idx_t i
  );
    logic [dircc_types_pkg::beat_width-1:0] w;
    case (i)
      0:       w = p.dest_addr.hw_addr;
      1:       w = {p.dest_addr.sw_addr, p.dest_addr.port, p.dest_addr.flag, 8'h00};
      2:       w = p.src_addr.hw_addr;
      3:       w = {p.src_addr.sw_addr, p.src_addr.port, p.src_addr.flag, 8'h00};
      4:       w = p.lamport;
      5:       w = p.data[31:0];
      6:       w = p.data[63:32];
      default: w = p.data[95:64];
    endcase
    return w;
  endfunction

  st_fifo #(
    .payload_t (dircc_types_pkg::packet_t),
    .depth     (dircc_types_pkg::tx_queue_depth)
  ) tx_queue (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_valid  (pkt_in_valid),
    .in_data   (pkt_in),
    .in_ready  (pkt_in_ready),
    .out_valid (head_valid),
    .out_data  (head_pkt),
    .out_ready (pop)
  );

  assign tx_beat.ready = tx_ready;
  assign pop  = tx_beat.valid && tx_beat.ready && tx_beat.endofpacket;
  assign load = head_valid && !drained && (!tx_beat.valid || tx_beat.ready);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      beat_idx              <= '0;
      drained               <= 1'b0;
      tx_beat.valid         <= 1'b0;
      tx_beat.startofpacket <= 1'b0;
      tx_beat.endofpacket   <= 1'b0;
    end else begin
      if (load) begin
        tx_beat.valid         <= 1'b1;
        tx_beat.startofpacket <= (beat_idx == '0);
        tx_beat.endofpacket   <= (beat_idx == dircc_types_pkg::last_beat);
        if (beat_idx == dircc_types_pkg::last_beat) begin
          beat_idx <= '0;
          drained  <= 1'b1;
        end else begin
          beat_idx <= beat_idx + 1'b1;
        end
      end else if (tx_beat.ready) begin
        tx_beat.valid <= 1'b0;            // beat gone, nothing to follow yet
      end
      if (pop) begin
        drained <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      tx_beat.data <= beat_word(head_pkt, beat_idx);
    end
  end

  assign tx_data          = tx_beat.data;
  assign tx_startofpacket = tx_beat.startofpacket;
  assign tx_endofpacket   = tx_beat.endofpacket;
  assign tx_valid         = tx_beat.valid;

endmodule

//--- hw/dircc_net_port.sv
`timescale 1ns/1ps

module dircc_net_port (
  input  logic                                   clk,
  input  logic                                   reset_n,
  input  logic                                   booting,

  input  logic [dircc_types_pkg::beat_width-1:0] rx_data,
  input  logic                                   rx_startofpacket,
  input  logic                                   rx_endofpacket,
  input  logic                                   rx_valid,
  output logic                                   rx_ready,

  output logic                                   pkt_out_valid,
  output dircc_types_pkg::packet_t               pkt_out,
  output logic                                   receive_done,
  output logic                                   receive_nearly_done,
  output logic                                   framing_error,

  input  logic                                   pkt_in_valid,
  input  dircc_types_pkg::packet_t               pkt_in,
  output logic                                   pkt_in_ready,

  output logic [dircc_types_pkg::beat_width-1:0] tx_data,
  output logic                                   tx_startofpacket,
  output logic                                   tx_endofpacket,
  output logic                                   tx_valid,
  input  logic                                   tx_ready
);

  dircc_avalon_st_packet_receiver receiver (
    .clk                 (clk),
    .reset_n             (reset_n),
    .booting             (booting),
    .rx_data             (rx_data),
    .rx_startofpacket    (rx_startofpacket),
    .rx_endofpacket      (rx_endofpacket),
    .rx_valid            (rx_valid),
    .rx_ready            (rx_ready),
    .pkt_out_valid       (pkt_out_valid),
    .pkt_out             (pkt_out),
    .receive_done        (receive_done),
    .receive_nearly_done (receive_nearly_done),
    .framing_error       (framing_error)
  );

  dircc_avalon_st_packet_sender sender (
    .clk              (clk),
    .reset_n          (reset_n),
    .pkt_in_valid     (pkt_in_valid),
    .pkt_in           (pkt_in),
    .pkt_in_ready     (pkt_in_ready),
    .tx_data          (tx_data),
    .tx_startofpacket (tx_startofpacket),
    .tx_endofpacket   (tx_endofpacket),
    .tx_valid         (tx_valid),
    .tx_ready         (tx_ready)
  );

endmodule

//--- bench/dircc_net_port_props.sv
`timescale 1ns/1ps

module dircc_net_port_props (
  input logic        clk,
  input logic        reset_n,
  input logic [31:0] tx_data,
  input logic        tx_startofpacket,
  input logic        tx_endofpacket,
  input logic        tx_valid,
  input logic        tx_ready,
  input logic        pkt_out_valid,
  input logic        receive_done,
  input logic        receive_nearly_done,
  input logic        framing_error
);

  logic near_seen; // nearly_done seen in the current frame

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      near_seen <= 1'b0;
    end else if (receive_done || framing_error) begin
      near_seen <= 1'b0;
    end else if (receive_nearly_done) begin
      near_seen <= 1'b1;
    end
  end

  tx_held: assert property (@(posedge clk) disable iff (!reset_n)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data)
      && $stable(tx_startofpacket) && $stable(tx_endofpacket))
    else $error("tx beat changed under back-pressure");

  done_with_packet: assert property (@(posedge clk) disable iff (!reset_n)
    receive_done == pkt_out_valid)
    else $error("receive_done and pkt_out_valid disagree");

  near_before_done: assert property (@(posedge clk) disable iff (!reset_n)
    receive_done |-> near_seen)
    else $error("receive_done without receive_nearly_done in the frame");

  quiet_in_reset: assert property (@(posedge clk)
    !reset_n |-> !tx_valid && !pkt_out_valid && !receive_done
      && !receive_nearly_done && !framing_error)
    else $error("output pulse during reset");

endmodule

//--- bench/dircc_net_port_tb.sv
`timescale 1ns/1ps

module dircc_net_port_tb;

  localparam int max_records = 32;

  logic                     clk;
  logic                     reset_n;
  logic                     booting;
  logic [31:0]              rx_data;
  logic                     rx_startofpacket;
  logic                     rx_endofpacket;
  logic                     rx_valid;
  logic                     rx_ready;
  logic                     pkt_out_valid;
  dircc_types_pkg::packet_t pkt_out;
  logic                     receive_done;
  logic                     receive_nearly_done;
  logic                     framing_error;
  logic                     pkt_in_valid;
  dircc_types_pkg::packet_t pkt_in;
  logic                     pkt_in_ready;
  logic [31:0]              tx_data;
  logic                     tx_startofpacket;
  logic                     tx_endofpacket;
  logic                     tx_valid;
  logic                     tx_ready;

  string                    rec_name [max_records];
  string                    rec_dir [max_records];
  string                    rec_corrupt [max_records];
  dircc_types_pkg::packet_t rec_pkt [max_records];
  int                       rec_boot [max_records];
  int                       n_records;
  int                       watchdog_cycles;
  bit                       loaded;

  logic [33:0]              exp_tx [$]; // {data, sop, eop}
  string                    cur_name;
  int                       test_errors;
  int                       pass_count;
  int                       fail_count;
  logic [31:0]              rx_rng = 32'h2a08_46cc;
  logic [31:0]              tx_rng = 32'h2a08_46cc;

  int                       done_cnt;
  int                       near_cnt;
  int                       ferr_cnt;
  bit                       near_late;
  dircc_types_pkg::packet_t got_pkt;

  dircc_net_port UUT (.*);

  bind dircc_net_port dircc_net_port_props props (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // beat i of a frame, laid out from the packet fields
  function automatic logic [31:0] model_word(input dircc_types_pkg::packet_t p, input int i);
    logic [255:0] frame;
    frame = {p.data[95:64], p.data[63:32], p.data[31:0], p.lamport,
             {p.src_addr[23:0], 8'h00}, p.src_addr[55:24],
             {p.dest_addr[23:0], 8'h00}, p.dest_addr[55:24]};
    return frame[i*32 +: 32];
  endfunction

  // receiver outputs, sampled just after the edge
  always @(posedge clk) begin
    #1;
    if (reset_n) begin
      if (framing_error) ferr_cnt++;
      if (receive_done && near_cnt == 0) near_late = 1'b1;
      if (receive_nearly_done) near_cnt++;
      if (pkt_out_valid) begin
        done_cnt++;
        got_pkt = pkt_out;
      end
    end
  end

  // tx side: random back-pressure and beat check
  always @(negedge clk) begin
    logic [33:0] exp;
    logic [33:0] act;
    tx_rng = xorshift(tx_rng);
    tx_ready = (tx_rng[1:0] != 2'b00);
    #1;
    if (reset_n && tx_valid && tx_ready) begin
      act = {tx_data, tx_startofpacket, tx_endofpacket};
      if (exp_tx.size() == 0) begin
        $display("%s: tx beat %h appeared with no packet pending", cur_name, act);
        test_errors++;
      end else begin
        exp = exp_tx.pop_front();
        if (act != exp) begin
          $display("Mismatch %s tx beat: expected %h actual %h", cur_name, exp, act);
          test_errors++;
        end
      end
    end
  end

  task automatic send_beat(input logic [31:0] d, input logic sop, input logic eop);
    rx_rng = xorshift(rx_rng);
    while (rx_rng[1:0] == 2'b00) begin // idle gap
      rx_valid = 1'b0;
      @(negedge clk);
      rx_rng = xorshift(rx_rng);
    end
    rx_data          = d;
    rx_startofpacket = sop;
    rx_endofpacket   = eop;
    rx_valid         = 1'b1;
    while (!rx_ready) @(negedge clk);
    @(negedge clk);
    rx_valid = 1'b0;
  endtask

  task automatic send_frame(input dircc_types_pkg::packet_t p, input string corrupt);
    if (corrupt == "nosop") begin
      for (int i = 1; i < 4; i++) send_beat(model_word(p, i), 1'b0, 1'b0);
    end else if (corrupt == "earlyeop") begin
      send_beat(model_word(p, 0), 1'b1, 1'b0);
      send_beat(model_word(p, 1), 1'b0, 1'b0);
      send_beat(model_word(p, 2), 1'b0, 1'b1);
    end else if (corrupt == "restart") begin
      send_beat(model_word(p, 0), 1'b1, 1'b0);
      for (int i = 1; i < 4; i++) send_beat(model_word(p, i), 1'b0, 1'b0);
    end
    for (int i = 0; i < dircc_types_pkg::frame_beats; i++) begin
      send_beat(model_word(p, i), i == 0, i == dircc_types_pkg::frame_beats - 1);
    end
  endtask

  task automatic run_rx(input int r);
    bit saw_full;
    int exp_ferr;
    saw_full  = 1'b0;
    exp_ferr  = (rec_corrupt[r] == "none") ? 0 : 1;
    done_cnt  = 0;
    near_cnt  = 0;
    ferr_cnt  = 0;
    near_late = 1'b0;
    booting   = (rec_boot[r] > 0);
    fork
      send_frame(rec_pkt[r], rec_corrupt[r]);
      begin
        repeat (rec_boot[r]) begin
          @(negedge clk);
          if (!rx_ready) saw_full = 1'b1;
        end
        if (done_cnt != 0) begin
          $display("%s: packet delivered while booting", cur_name);
          test_errors++;
        end
        booting = 1'b0;
      end
    join
    while (done_cnt == 0) @(negedge clk);
    repeat (3) @(negedge clk);
    if (done_cnt != 1) begin
      $display("%s: expected one packet, got %0d", cur_name, done_cnt);
      test_errors++;
    end
    if (got_pkt != rec_pkt[r]) begin
      $display("Mismatch %s pkt_out: expected %h actual %h", cur_name, rec_pkt[r], got_pkt);
      test_errors++;
    end
    if (near_cnt != 1 || near_late) begin
      $display("%s: receive_nearly_done seen %0d times, not once before done",
               cur_name, near_cnt);
      test_errors++;
    end
    if (ferr_cnt != exp_ferr) begin
      $display("Mismatch %s framing_error count: expected %0d actual %0d",
               cur_name, exp_ferr, ferr_cnt);
      test_errors++;
    end
    if (rec_boot[r] > 0 && !saw_full) begin
      $display("%s: rx_ready never fell while booting", cur_name);
      test_errors++;
    end
  endtask

  task automatic run_tx(input int r);
    for (int i = 0; i < dircc_types_pkg::frame_beats; i++) begin
      exp_tx.push_back({model_word(rec_pkt[r], i), i == 0,
                        i == dircc_types_pkg::frame_beats - 1});
    end
    pkt_in       = rec_pkt[r];
    pkt_in_valid = 1'b1;
    #1;
    while (!pkt_in_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    pkt_in_valid = 1'b0;
    while (exp_tx.size() != 0) @(negedge clk);
  endtask

  task automatic report_test();
    if (test_errors == 0) begin
      pass_count++;
      $display("ok   %s", cur_name);
    end else begin
      fail_count++;
      $display("FAIL %s (%0d errors)", cur_name, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    int    fd;
    int    n;
    int    code;
    string line;
    string name;
    string dir;
    string corrupt;
    logic [31:0] dhw;
    logic [15:0] dsw;
    logic [6:0]  dport;
    logic        dflag;
    logic [31:0] shw;
    logic [15:0] ssw;
    logic [6:0]  sport;
    logic        sflag;
    logic [31:0] lam;
    logic [95:0] data;
    int          boot;
    reset_n          = 1'b0;
    booting          = 1'b0;
    rx_data          = '0;
    rx_startofpacket = 1'b0;
    rx_endofpacket   = 1'b0;
    rx_valid         = 1'b0;
    pkt_in_valid     = 1'b0;
    pkt_in           = '0;
    tx_ready         = 1'b0;
    cur_name         = "reset";
    test_errors      = 0;
    pass_count       = 0;
    fail_count       = 0;
    n_records        = 0;
    watchdog_cycles  = 40;
    fd = $fopen("bench/dircc_net_port_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file");
      fail_count++;
    end else begin
      while (!$feof(fd) && n_records < max_records) begin
        line = "";
        code = $fgets(line, fd);
        if (code == 0 || line.len() < 2 || line[0] == "#") continue;
        n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %d %s", name, dir, dhw, dsw,
                    dport, dflag, shw, ssw, sport, sflag, lam, data, boot, corrupt);
        if (n != 14) begin
          $display("trace line could not be parsed: %s", line);
          fail_count++;
          continue;
        end
        rec_name[n_records]    = name;
        rec_dir[n_records]     = dir;
        rec_corrupt[n_records] = corrupt;
        rec_boot[n_records]    = boot;
        rec_pkt[n_records]     = {dhw, dsw, dport, dflag, shw, ssw, sport, sflag, lam, data};
        watchdog_cycles += dircc_types_pkg::frame_beats * 20 + boot;
        n_records++;
      end
      $fclose(fd);
    end
    loaded = 1'b1;

    repeat (8) @(negedge clk);
    reset_n  = 1'b1;
    cur_name = "reset_idle";
    repeat (4) begin
      @(negedge clk);
      if (tx_valid || pkt_out_valid || receive_done || receive_nearly_done
          || framing_error) begin
        $display("%s: an output rose before any stimulus", cur_name);
        test_errors++;
      end
    end
    report_test();

    for (int r = 0; r < n_records; r++) begin
      cur_name = rec_name[r];
      if (rec_dir[r] == "tx") run_tx(r);
      else run_rx(r);
      report_test();
    end

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    repeat (watchdog_cycles + 8) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- dircc_net_port.f
hw/dircc_types_pkg.sv
hw/st_beat_if.sv
hw/st_fifo.sv
hw/dircc_avalon_st_packet_receiver.sv
hw/dircc_avalon_st_packet_sender.sv
hw/dircc_net_port.sv
bench/dircc_net_port_props.sv
bench/dircc_net_port_tb.sv

//--- Makefile
# Verilator build and run for the network port testbench

VERILATOR ?= verilator
TOP       := dircc_net_port_tb
FILELIST  := dircc_net_port.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP)

SOURCES   := $(shell grep -v '^+' $(FILELIST))
TRACE     := bench/dircc_net_port_trace.txt
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(BIN) $(TRACE)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- bench/dircc_net_port_trace.txt
# name dir dest_hw dest_sw dest_port dest_flag src_hw src_sw src_port src_flag
# lamport data(96 bit hex) booting_cycles corrupt(none|nosop|earlyeop|restart)
rx_basic rx 00000001 0010 01 0 00000002 0020 02 1 00000005 0000000a0000000b0000000c 0 none
rx_all_ones rx ffffffff ffff 7f 1 ffffffff ffff 7f 1 ffffffff ffffffffffffffffffffffff 0 none
rx_pattern rx a5a5a5a5 5a5a 55 0 5a5a5a5a a5a5 2a 1 12345678 deadbeefcafef00d01234567 0 none
rx_boot_short rx 10000000 0100 03 1 20000000 0200 04 0 00000100 111111112222222233333333 20 none
rx_boot_long rx 3c3c3c3c 1234 11 0 c3c3c3c3 4321 22 1 00000101 444444445555555566666666 60 none
rx_nosop rx 0badc0de 00aa 0f 0 0000beef 00bb 70 1 00000200 777777778888888899999999 0 nosop
rx_after_nosop rx 00000010 0001 01 1 00000011 0002 02 0 00000201 aaaaaaaabbbbbbbbcccccccc 0 none
rx_early_eop rx 87654321 fedc 33 1 13579bdf 2468 44 0 00000300 0f0f0f0ff0f0f0f000ff00ff 0 earlyeop
rx_after_eop rx 00000020 0003 05 0 00000021 0004 06 1 00000301 ddddddddeeeeeeee01010101 0 none
rx_restart rx 00c0ffee 0c0c 0c 1 00facade 0d0d 0d 0 00000400 1020304050607080a0b0c0d0 0 restart
rx_after_restart rx 00000030 0005 07 1 00000031 0006 08 0 00000401 0000000100000002ffffffff 0 none
rx_boot_restart rx 55555555 aaaa 6a 0 aaaaaaaa 5555 15 1 00000500 fedcba9876543210abcdef01 40 restart
tx_basic tx 00000001 0010 01 0 00000002 0020 02 1 00000005 0000000a0000000b0000000c 0 none
tx_all_ones tx ffffffff ffff 7f 1 ffffffff ffff 7f 1 ffffffff ffffffffffffffffffffffff 0 none
tx_pattern tx a5a5a5a5 5a5a 55 0 5a5a5a5a a5a5 2a 1 12345678 deadbeefcafef00d01234567 0 none
tx_second tx 00c0ffee 0c0c 0c 1 00facade 0d0d 0d 0 00000400 1020304050607080a0b0c0d0 0 none
tx_third tx 87654321 fedc 33 1 13579bdf 2468 44 0 00000300 0f0f0f0ff0f0f0f000ff00ff 0 none
tx_zero tx 00000000 0000 00 0 00000000 0000 00 0 00000000 000000000000000000000000 0 none
